//--- Makefile
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f verilog.f --top-module dma_tb

sim:
	verilator --binary --timing --assert -f verilog.f --top-module dma_tb \
		-Mdir obj_dir -o dma_sim
	./obj_dir/dma_sim +verilator+error+limit+1000 2>&1 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "TEST PASSED" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

//--- dma_pkg.sv
// DMA engine types
// Field widths, request layout, host bus and memory port bundles
`default_nettype none

`include "dma_settings.svh"

package dma_pkg;

  // Widths that carry a meaning
  typedef logic [$clog2(`DMA_ENTRIES)-1:0] entry_idx_t;
  typedef logic [$clog2(`DMA_MEM_WORDS)-1:0] mem_addr_t;
  // Word count, zero means nothing to copy
  typedef logic [7:0] xfer_size_t;
  typedef logic [`DMA_DATA_W-1:0] data_t;
  typedef logic [`DMA_HOST_ADDR_W-1:0] host_addr_t;

  // One transfer request
  // dir 0 copies laddr to raddr, dir 1 the other way
  typedef struct packed {
    mem_addr_t laddr;
    xfer_size_t size;
    mem_addr_t raddr;
    logic dir;
  } dma_request_t;

  // One-hot select of the request fields
  typedef struct packed {
    logic laddr;
    logic size;
    logic raddr;
    logic dir;
  } field_sel_t;

  // Host bus, single-cycle strobe
  typedef struct packed {
    logic strobe;
    logic write;
    host_addr_t addr;
    data_t wdata;
  } host_req_t;

  typedef struct packed {
    logic rvalid;
    data_t rdata;
  } host_rsp_t;

  // A single memory port
  typedef struct packed {
    logic en;
    mem_addr_t addr;
    data_t data;
  } mem_port_t;

  typedef enum logic [2:0] {
    IDLE,
    LOAD,
    COPY,
    DRAIN,
    FINISH
  } engine_state_t;

endpackage

`default_nettype wire

//--- dma_props.sv
// DMA engine protocol properties
// Bound into the top level, watches the host read return,
// the completion pulse and the interrupt lines out of reset
`timescale 1ns/100ps
`default_nettype none

`include "dma_settings.svh"

module dma_props (
  input  wire logic                    clk,
  input  wire logic                    rst,
  input  wire dma_pkg::host_req_t      host_req,
  input  wire dma_pkg::host_rsp_t      host_rsp,
  input  wire logic                    done_en,
  input  wire logic [`DMA_ENTRIES-1:0] irq
);

  // Failure tallies, summed up by the testbench at the end
  int unsigned rvalid_fails = 0;
  int unsigned pulse_fails = 0;
  int unsigned irq_fails = 0;

  logic rd_strobe;

  assign rd_strobe = host_req.strobe && !host_req.write;

  ////////////////////
  // Host read return
  ////////////////////

  // Every read strobe answered on the next cycle
  assert property (@(posedge clk) disable iff (rst) rd_strobe |=> host_rsp.rvalid)
    else begin
      $error("rvalid missing one cycle after a read strobe");
      rvalid_fails++;
    end

  // And no answer without a strobe one cycle before
  assert property (@(posedge clk) disable iff (rst) host_rsp.rvalid |-> $past(rd_strobe))
    else begin
      $error("rvalid without a read strobe in the previous cycle");
      rvalid_fails++;
    end

  ////////////////////
  // Engine and irq
  ////////////////////

  // Completion is a single-cycle pulse
  assert property (@(posedge clk) disable iff (rst) done_en |=> !done_en)
    else begin
      $error("done_en held for more than one cycle");
      pulse_fails++;
    end

  // First cycle out of reset has all lines low
  assert property (@(posedge clk) (!rst && $past(rst)) |-> (irq == '0))
    else begin
      $error("irq lines not zero right after reset");
      irq_fails++;
    end

endmodule

bind dma_top dma_props dma_props_i (
  .clk(clk), .rst(rst), .host_req(host_req), .host_rsp(host_rsp),
  .done_en(done_en), .irq(irq)
);

`default_nettype wire

//--- dma_reg_decode.sv
// DMA host register decode
// Turns host strobes into table field writes, valid and ack commands
// and scratch memory accesses, and returns read data one cycle later
`timescale 1ns/100ps
`default_nettype none

`include "dma_settings.svh"

module dma_reg_decode (
  input  wire logic                    clk,
  input  wire logic                    rst,
  input  wire dma_pkg::host_req_t      host_req,
  output dma_pkg::host_rsp_t           host_rsp,
  // Table side
  input  wire dma_pkg::dma_request_t   tbl_read_req,
  input  wire logic [`DMA_ENTRIES-1:0] pending,
  input  wire logic [`DMA_ENTRIES-1:0] done,
  output dma_pkg::dma_request_t        write_req,
  output dma_pkg::field_sel_t          write_sel,
  output dma_pkg::entry_idx_t          write_pos,
  output logic                         write_en,
  output dma_pkg::entry_idx_t          valid_pos,
  output logic                         valid_set,
  output logic                         valid_en,
  output logic                         ack_en,
  output dma_pkg::entry_idx_t          read_pos,
  // Memory side
  input  wire dma_pkg::data_t          mem_rdata,
  output dma_pkg::mem_port_t           host_rd,
  output dma_pkg::mem_port_t           host_wr
);

  localparam int OFS_W = $clog2(`DMA_REG_ENTRY_STRIDE);
  localparam int IDX_W = $clog2(`DMA_ENTRIES);

  logic [OFS_W-1:0] ofs;
  dma_pkg::entry_idx_t entry;
  logic is_entry;
  logic is_status;
  logic is_mem;
  logic is_ctrl;
  logic rd_strobe;
  logic wr_strobe;
  dma_pkg::data_t status_word;
  // Read pipeline, one cycle deep
  logic rvalid_q;
  logic rd_mem_q;
  dma_pkg::data_t rd_data_q;

  ////////////////////
  // Address split
  ////////////////////

  assign ofs = host_req.addr[OFS_W-1:0];
  assign entry = host_req.addr[OFS_W +: IDX_W];
  // Entry windows sit at the bottom of the map
  assign is_entry = host_req.addr <
                    dma_pkg::host_addr_t'(`DMA_ENTRIES * `DMA_REG_ENTRY_STRIDE);
  assign is_status = (host_req.addr == `DMA_REG_STATUS);
  assign is_mem = (host_req.addr >= `DMA_REG_MEM_BASE);
  assign is_ctrl = is_entry && (ofs == `DMA_OFS_CTRL);

  assign rd_strobe = host_req.strobe && !host_req.write;
  assign wr_strobe = host_req.strobe && host_req.write;

  ////////////////////
  // Table commands
  ////////////////////

  always_comb begin
    // Field writes, offsets 0 to 3 only
    write_en = wr_strobe && is_entry && (ofs < `DMA_OFS_CTRL);
    write_pos = entry;
    write_sel.laddr = (ofs == `DMA_OFS_LADDR);
    write_sel.size = (ofs == `DMA_OFS_SIZE);
    write_sel.raddr = (ofs == `DMA_OFS_RADDR);
    write_sel.dir = (ofs == `DMA_OFS_DIR);
    // Same data in every field, the select picks the live one
    write_req.laddr = dma_pkg::mem_addr_t'(host_req.wdata);
    write_req.size = dma_pkg::xfer_size_t'(host_req.wdata);
    write_req.raddr = dma_pkg::mem_addr_t'(host_req.wdata);
    write_req.dir = host_req.wdata[0];
    // Valid command on write, acknowledge on read
    valid_pos = entry;
    valid_set = host_req.wdata[0];
    valid_en = wr_strobe && is_ctrl;
    ack_en = rd_strobe && is_ctrl;
    read_pos = entry;
  end

  ////////////////////
  // Memory window
  ////////////////////

  always_comb begin
    host_rd.en = rd_strobe && is_mem;
    host_rd.addr = dma_pkg::mem_addr_t'(host_req.addr);
    host_rd.data = '0;
    host_wr.en = wr_strobe && is_mem;
    host_wr.addr = dma_pkg::mem_addr_t'(host_req.addr);
    host_wr.data = host_req.wdata;
  end

  ////////////////////
  // Read return
  ////////////////////

  // Done bits in the low byte, pending bits in the next
  always_comb begin
    status_word = '0;
    status_word[`DMA_ENTRIES-1:0] = done;
    status_word[8 +: `DMA_ENTRIES] = pending;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rvalid_q <= 1'b0;
      rd_mem_q <= 1'b0;
    end else begin
      rvalid_q <= rd_strobe;
      rd_mem_q <= rd_strobe && is_mem;
    end
  end

  // Table and status data captured at the strobe
  always_ff @(posedge clk) begin
    if (rd_strobe) begin
      rd_data_q <= '0;
      if (is_status) begin
        rd_data_q <= status_word;
      end else if (is_ctrl) begin
        rd_data_q[$bits(dma_pkg::dma_request_t)-1:0] <= tbl_read_req;
      end
    end
  end

  // Memory data arrives straight from the array a cycle later
  always_comb begin
    host_rsp.rvalid = rvalid_q;
    host_rsp.rdata = rd_mem_q ? mem_rdata : rd_data_q;
  end

endmodule

`default_nettype wire

//--- dma_request_table.sv
// DMA request table
// Holds the transfer requests, written one field at a time,
// plus per-entry valid and done bits and the interrupt lines
`timescale 1ns/100ps
`default_nettype none

`include "dma_settings.svh"

module dma_request_table (
  input  wire logic                    clk,
  input  wire logic                    rst,
  // Host field writes
  input  wire dma_pkg::dma_request_t   write_req,
  input  wire dma_pkg::field_sel_t     write_sel,
  input  wire dma_pkg::entry_idx_t     write_pos,
  input  wire logic                    write_en,
  // Valid command and acknowledge
  input  wire dma_pkg::entry_idx_t     valid_pos,
  input  wire logic                    valid_set,
  input  wire logic                    valid_en,
  input  wire logic                    ack_en,
  // Read ports, host and engine
  input  wire dma_pkg::entry_idx_t     read_pos,
  output dma_pkg::dma_request_t        read_req,
  input  wire dma_pkg::entry_idx_t     eng_pos,
  output dma_pkg::dma_request_t        eng_req,
  // Completion from the engine
  input  wire dma_pkg::entry_idx_t     done_pos,
  input  wire logic                    done_en,
  output logic [`DMA_ENTRIES-1:0]      pending,
  output logic [`DMA_ENTRIES-1:0]      done,
  output logic [`DMA_ENTRIES-1:0]      irq
);

  dma_pkg::dma_request_t req_mem [`DMA_ENTRIES];
  dma_pkg::dma_request_t write_mask;
  logic [`DMA_ENTRIES-1:0] valid_q;
  logic [`DMA_ENTRIES-1:0] done_q;

  // Widen the one-hot select into a bit mask over the request
  always_comb begin
    write_mask.laddr = {$bits(dma_pkg::mem_addr_t){write_sel.laddr}};
    write_mask.size = {$bits(dma_pkg::xfer_size_t){write_sel.size}};
    write_mask.raddr = {$bits(dma_pkg::mem_addr_t){write_sel.raddr}};
    write_mask.dir = write_sel.dir;
  end

  ////////////////////
  // Request storage
  ////////////////////

  always_ff @(posedge clk) begin
    if (write_en) begin
      // Untouched fields keep their old value
      req_mem[write_pos] <= (req_mem[write_pos] & ~write_mask) |
                            (write_req & write_mask);
    end
  end

  assign read_req = req_mem[read_pos];
  assign eng_req = req_mem[eng_pos];

  ////////////////////
  // Valid and done
  ////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
      done_q <= '0;
    end else begin
      for (int i = 0; i < `DMA_ENTRIES; i++) begin
        if (valid_en && (valid_pos == dma_pkg::entry_idx_t'(i))) begin
          // Start or cancel, a restart forgets the old completion
          valid_q[i] <= valid_set;
          done_q[i] <= 1'b0;
        end else if (ack_en && (valid_pos == dma_pkg::entry_idx_t'(i)) && done_q[i]) begin
          // Host has seen the completion
          valid_q[i] <= 1'b0;
          done_q[i] <= 1'b0;
        end else if (done_en && (done_pos == dma_pkg::entry_idx_t'(i))) begin
          done_q[i] <= 1'b1;
        end
      end
    end
  end

  // Waiting for the engine
  assign pending = valid_q & ~done_q;
  assign done = done_q;
  // One line per entry, up until acknowledged
  assign irq = valid_q & done_q;

endmodule

`default_nettype wire

//--- dma_scratch_mem.sv
// DMA scratch memory
// One read and one write port, synchronous read, host before engine
`timescale 1ns/100ps
`default_nettype none

`include "dma_settings.svh"

module dma_scratch_mem (
  input  wire logic               clk,
  input  wire dma_pkg::mem_port_t host_rd,
  input  wire dma_pkg::mem_port_t host_wr,
  input  wire dma_pkg::mem_port_t eng_rd,
  input  wire dma_pkg::mem_port_t eng_wr,
  output dma_pkg::data_t          rdata,
  output logic                    eng_stall
);

  dma_pkg::data_t mem [`DMA_MEM_WORDS];
  dma_pkg::mem_port_t rd_port;
  dma_pkg::mem_port_t wr_port;

  // Any host access takes the whole cycle from the engine
  assign eng_stall = host_rd.en || host_wr.en;

  always_comb begin
    rd_port = eng_rd;
    wr_port = eng_wr;
    // Stalled engine access is dropped, the engine retries it
    if (eng_stall) begin
      rd_port = host_rd;
      wr_port = host_wr;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_port.en) begin
      mem[wr_port.addr] <= wr_port.data;
    end
    // Output holds when nobody reads
    if (rd_port.en) begin
      rdata <= mem[rd_port.addr];
    end
  end

endmodule

`default_nettype wire

//--- dma_settings.svh
// DMA engine build settings
// Table size, memory geometry and the host register map
`ifndef DMA_SETTINGS_SVH
`define DMA_SETTINGS_SVH

// Request table entries
`define DMA_ENTRIES 4

// Scratch memory geometry
`define DMA_MEM_WORDS 256
`define DMA_DATA_W 32

// Host address width, in words
`define DMA_HOST_ADDR_W 10

// One window of registers per entry, starting at address 0
`define DMA_REG_ENTRY_STRIDE 8
`define DMA_REG_STATUS 10'h020
// Memory window fills the upper half of the host space
`define DMA_REG_MEM_BASE 10'h200

// Offsets inside an entry window
`define DMA_OFS_LADDR 3'd0
`define DMA_OFS_SIZE 3'd1
`define DMA_OFS_RADDR 3'd2
`define DMA_OFS_DIR 3'd3
`define DMA_OFS_CTRL 3'd4

`endif

//--- dma_tb.sv
// DMA engine testbench
// Programs the request table over the host bus, runs copies in both
// directions and checks memory against a behavioural model
`timescale 1ns/100ps
`default_nettype none

`include "dma_settings.svh"

module dma_tb;

  // Fill, three full memory sweeps and the copies need well under this
  localparam int TIMEOUT_CYCLES = 20000;
  localparam int MEM_BASE = `DMA_REG_MEM_BASE;

  logic clk;
  logic rst;
  dma_pkg::host_req_t host_req;
  dma_pkg::host_rsp_t host_rsp;
  logic [`DMA_ENTRIES-1:0] irq;

  // Behavioural copy of the scratch memory
  dma_pkg::data_t model_mem [`DMA_MEM_WORDS];
  integer seed;
  int errors = 0;
  int cycle_count = 0;

  dma_top dma_top_i (
    .clk(clk), .rst(rst), .host_req(host_req), .host_rsp(host_rsp), .irq(irq)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Run limit
  initial begin
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("*** TEST FAILED ***");
    $finish;
  end

  ////////////////////
  // Host bus tasks
  ////////////////////

  function automatic dma_pkg::host_addr_t entry_addr(input int e, input int ofs);
    return dma_pkg::host_addr_t'(e * `DMA_REG_ENTRY_STRIDE + ofs);
  endfunction

  task automatic host_write(input dma_pkg::host_addr_t addr, input dma_pkg::data_t data);
    @(posedge clk);
    host_req <= '{strobe: 1'b1, write: 1'b1, addr: addr, wdata: data};
    @(posedge clk);
    host_req <= '0;
  endtask

  // Data taken at the falling edge once rvalid is up
  task automatic host_read(input dma_pkg::host_addr_t addr, output dma_pkg::data_t data);
    @(posedge clk);
    host_req <= '{strobe: 1'b1, write: 1'b0, addr: addr, wdata: '0};
    @(posedge clk);
    host_req <= '0;
    @(negedge clk);
    while (!host_rsp.rvalid) begin
      @(negedge clk);
    end
    data = host_rsp.rdata;
  endtask

  task automatic check_word(input dma_pkg::data_t actual, input dma_pkg::data_t expected,
                            input string what);
    assert (actual === expected) else begin
      errors++;
      $display("[ERROR] %0t: %s read 0x%08h, expected 0x%08h", $time, what, actual, expected);
    end
  endtask

  task automatic check_irq(input logic [`DMA_ENTRIES-1:0] expected);
    assert (irq === expected) else begin
      errors++;
      $display("[ERROR] %0t: irq is 0x%0h, expected 0x%0h", $time, irq, expected);
    end
  endtask

  ////////////////////
  // Table helpers
  ////////////////////

  task automatic program_entry(input int e, input dma_pkg::dma_request_t req);
    host_write(entry_addr(e, `DMA_OFS_LADDR), dma_pkg::data_t'(req.laddr));
    host_write(entry_addr(e, `DMA_OFS_SIZE), dma_pkg::data_t'(req.size));
    host_write(entry_addr(e, `DMA_OFS_RADDR), dma_pkg::data_t'(req.raddr));
    host_write(entry_addr(e, `DMA_OFS_DIR), dma_pkg::data_t'(req.dir));
  endtask

  task automatic start_entry(input int e);
    host_write(entry_addr(e, `DMA_OFS_CTRL), 32'd1);
  endtask

  // Offset 4 read, also the acknowledge of a done entry
  task automatic expect_request(input int e, input dma_pkg::dma_request_t req);
    dma_pkg::data_t rd;
    host_read(entry_addr(e, `DMA_OFS_CTRL), rd);
    check_word(rd, dma_pkg::data_t'(req), $sformatf("Entry %0d request", e));
  endtask

  task automatic expect_status(input dma_pkg::data_t expected);
    dma_pkg::data_t rd;
    host_read(`DMA_REG_STATUS, rd);
    check_word(rd, expected, "Status");
  endtask

  // Lines sampled at the falling edge only
  task automatic wait_irq(input int e);
    @(negedge clk);
    while (!irq[e]) begin
      @(negedge clk);
    end
  endtask

  ////////////////////
  // Memory model
  ////////////////////

  task automatic copy_in_model(input int src, input int dst, input int len);
    for (int i = 0; i < len; i++) begin
      model_mem[(dst + i) % `DMA_MEM_WORDS] = model_mem[(src + i) % `DMA_MEM_WORDS];
    end
  endtask

  task automatic compare_memory(input int lo, input int count);
    int a;
    dma_pkg::data_t rd;
    for (int i = 0; i < count; i++) begin
      a = (lo + i) % `DMA_MEM_WORDS;
      host_read(dma_pkg::host_addr_t'(MEM_BASE + a), rd);
      check_word(rd, model_mem[a], $sformatf("Memory word 0x%02h", a));
    end
  endtask

  ////////////////////
  // Test sequence
  ////////////////////

  initial begin
    dma_pkg::dma_request_t req [`DMA_ENTRIES];
    dma_pkg::dma_request_t one;
    dma_pkg::data_t word;
    int src [`DMA_ENTRIES];
    int dst [`DMA_ENTRIES];
    int len [`DMA_ENTRIES];
    int e;
    int prop_fails;
    seed = 32'hedd9;
    host_req <= '0;
    rst <= 1'b1;
    repeat (10) @(posedge clk);
    rst <= 1'b0;

    // Quiet after reset
    @(negedge clk);
    check_irq('0);
    expect_status(32'h0);

    // Fill pattern carries the whole address in the upper half
    for (int a = 0; a < `DMA_MEM_WORDS; a++) begin
      word = {8'(a), 8'(~a), 16'($random(seed))};
      model_mem[a] = word;
      host_write(dma_pkg::host_addr_t'(MEM_BASE + a), word);
    end

    // Field writes touch one field only
    one = '{laddr: 8'h11, size: 8'h22, raddr: 8'h33, dir: 1'b1};
    program_entry(0, one);
    expect_request(0, one);
    host_write(entry_addr(0, `DMA_OFS_SIZE), 32'h5a);
    one.size = 8'h5a;
    expect_request(0, one);
    host_write(entry_addr(0, `DMA_OFS_DIR), 32'h0);
    one.dir = 1'b0;
    expect_request(0, one);
    host_write(entry_addr(0, `DMA_OFS_RADDR), 32'h77);
    one.raddr = 8'h77;
    expect_request(0, one);

    // Local to remote copy
    one = '{laddr: 8'h10, size: 8'd8, raddr: 8'h80, dir: 1'b0};
    program_entry(0, one);
    start_entry(0);
    wait_irq(0);
    check_irq(4'b0001);
    copy_in_model(8'h10, 8'h80, 8);
    compare_memory(8'h80, 8);
    compare_memory(8'h10, 8);
    expect_status(32'h0001);
    expect_request(0, one);
    check_irq('0);
    expect_status(32'h0);

    // Remote to local copy, then an empty transfer
    req[1] = '{laddr: 8'h20, size: 8'd5, raddr: 8'ha0, dir: 1'b1};
    program_entry(1, req[1]);
    start_entry(1);
    wait_irq(1);
    copy_in_model(8'ha0, 8'h20, 5);
    req[2] = '{laddr: 8'h30, size: 8'd0, raddr: 8'h40, dir: 1'b0};
    program_entry(2, req[2]);
    start_entry(2);
    wait_irq(2);
    check_irq(4'b0110);
    expect_request(1, req[1]);
    expect_request(2, req[2]);
    check_irq('0);
    compare_memory(0, `DMA_MEM_WORDS);

    // Four entries at once, each inside its own quarter of memory
    // Sources in the lower half of a quarter, destinations in the upper
    for (int i = 0; i < `DMA_ENTRIES; i++) begin
      src[i] = i * 64 + ($random(seed) & 15);
      dst[i] = i * 64 + 32 + ($random(seed) & 15);
      len[i] = 1 + ($random(seed) & 15);
      req[i].size = 8'(len[i]);
      req[i].dir = $random(seed) & 1;
      req[i].laddr = req[i].dir ? 8'(dst[i]) : 8'(src[i]);
      req[i].raddr = req[i].dir ? 8'(src[i]) : 8'(dst[i]);
      program_entry(i, req[i]);
    end
    for (int i = 0; i < `DMA_ENTRIES; i++) begin
      start_entry(i);
    end
    // Host reads of the unchanged sources steal cycles from the engine
    @(negedge clk);
    while (irq != 4'hf) begin
      e = $random(seed) & 3;
      compare_memory(src[e] + (($random(seed) & 255) % len[e]), 1);
    end
    expect_status(32'h000f);
    for (int i = 0; i < `DMA_ENTRIES; i++) begin
      copy_in_model(src[i], dst[i], len[i]);
      expect_request(i, req[i]);
    end
    check_irq('0);
    expect_status(32'h0);
    compare_memory(0, `DMA_MEM_WORDS);

    // Ack read of a running entry leaves it pending
    one = '{laddr: 8'h00, size: 8'd64, raddr: 8'h80, dir: 1'b0};
    program_entry(0, one);
    start_entry(0);
    expect_request(0, one);
    expect_status(32'h0100);
    check_irq('0);
    wait_irq(0);
    expect_status(32'h0001);
    expect_request(0, one);
    check_irq('0);
    expect_status(32'h0);
    copy_in_model(8'h00, 8'h80, 64);
    compare_memory(0, `DMA_MEM_WORDS);

    prop_fails = dma_top_i.dma_props_i.rvalid_fails + dma_top_i.dma_props_i.pulse_fails +
                 dma_top_i.dma_props_i.irq_fails;
    $display("Error count: %0d check errors, %0d assertion failures", errors, prop_fails);
    if (errors == 0 && prop_fails == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- dma_top.sv
// DMA engine top level
// Register decode, request table, transfer engine and scratch memory
`timescale 1ns/100ps
`default_nettype none

`include "dma_settings.svh"

module dma_top (
  input  wire logic               clk,
  input  wire logic               rst,
  input  wire dma_pkg::host_req_t host_req,
  output dma_pkg::host_rsp_t      host_rsp,
  output logic [`DMA_ENTRIES-1:0] irq
);

  // Decode to table
  dma_pkg::dma_request_t write_req;
  dma_pkg::field_sel_t write_sel;
  dma_pkg::entry_idx_t write_pos;
  logic write_en;
  dma_pkg::entry_idx_t valid_pos;
  logic valid_set;
  logic valid_en;
  logic ack_en;
  dma_pkg::entry_idx_t read_pos;
  dma_pkg::dma_request_t read_req;
  logic [`DMA_ENTRIES-1:0] pending;
  logic [`DMA_ENTRIES-1:0] done;
  // Engine to table
  dma_pkg::entry_idx_t eng_pos;
  dma_pkg::dma_request_t eng_req;
  dma_pkg::entry_idx_t done_pos;
  logic done_en;
  // Memory ports
  dma_pkg::mem_port_t host_rd;
  dma_pkg::mem_port_t host_wr;
  dma_pkg::mem_port_t eng_rd;
  dma_pkg::mem_port_t eng_wr;
  dma_pkg::data_t mem_rdata;
  logic eng_stall;

  dma_reg_decode dma_reg_decode_i (
    .clk(clk), .rst(rst), .host_req(host_req), .host_rsp(host_rsp),
    .tbl_read_req(read_req), .pending(pending), .done(done),
    .write_req(write_req), .write_sel(write_sel), .write_pos(write_pos),
    .write_en(write_en), .valid_pos(valid_pos), .valid_set(valid_set),
    .valid_en(valid_en), .ack_en(ack_en), .read_pos(read_pos),
    .mem_rdata(mem_rdata), .host_rd(host_rd), .host_wr(host_wr)
  );

  dma_request_table dma_request_table_i (
    .clk(clk), .rst(rst), .write_req(write_req), .write_sel(write_sel),
    .write_pos(write_pos), .write_en(write_en), .valid_pos(valid_pos),
    .valid_set(valid_set), .valid_en(valid_en), .ack_en(ack_en),
    .read_pos(read_pos), .read_req(read_req), .eng_pos(eng_pos),
    .eng_req(eng_req), .done_pos(done_pos), .done_en(done_en),
    .pending(pending), .done(done), .irq(irq)
  );

  dma_transfer_engine dma_transfer_engine_i (
    .clk(clk), .rst(rst), .pending(pending), .eng_pos(eng_pos),
    .eng_req(eng_req), .mem_rdata(mem_rdata), .eng_stall(eng_stall),
    .eng_rd(eng_rd), .eng_wr(eng_wr), .done_pos(done_pos), .done_en(done_en)
  );

  dma_scratch_mem dma_scratch_mem_i (
    .clk(clk), .host_rd(host_rd), .host_wr(host_wr), .eng_rd(eng_rd),
    .eng_wr(eng_wr), .rdata(mem_rdata), .eng_stall(eng_stall)
  );

endmodule

`default_nettype wire

//--- dma_transfer_engine.sv
// DMA transfer engine
// Picks pending entries round-robin and copies their words through the
// scratch memory, one read and one write in flight, then reports done
`timescale 1ns/100ps
`default_nettype none

`include "dma_settings.svh"

module dma_transfer_engine (
  input  wire logic                    clk,
  input  wire logic                    rst,
  input  wire logic [`DMA_ENTRIES-1:0] pending,
  // Request at eng_pos from the table
  output dma_pkg::entry_idx_t          eng_pos,
  input  wire dma_pkg::dma_request_t   eng_req,
  // Memory ports
  input  wire dma_pkg::data_t          mem_rdata,
  input  wire logic                    eng_stall,
  output dma_pkg::mem_port_t           eng_rd,
  output dma_pkg::mem_port_t           eng_wr,
  // Completion pulse
  output dma_pkg::entry_idx_t          done_pos,
  output logic                         done_en
);

  dma_pkg::engine_state_t state;
  // Copy pointers, wrap with the memory depth
  dma_pkg::mem_addr_t rd_addr;
  dma_pkg::mem_addr_t wr_addr;
  dma_pkg::xfer_size_t rd_left;
  // Read data held across a stalled write
  dma_pkg::data_t hold_data;
  logic rd_ret;
  logic wr_full;
  // Arbiter result
  logic found;
  dma_pkg::entry_idx_t next_pos;

  ////////////////////
  // Round-robin pick
  ////////////////////

  // Search starts just after the entry served last
  always_comb begin
    dma_pkg::entry_idx_t idx;
    found = 1'b0;
    next_pos = eng_pos;
    for (int i = 1; i <= `DMA_ENTRIES; i++) begin
      idx = eng_pos + dma_pkg::entry_idx_t'(i);
      if (!found && pending[idx]) begin
        found = 1'b1;
        next_pos = idx;
      end
    end
  end

  ////////////////////
  // Memory ports
  ////////////////////

  always_comb begin
    // COPY always has a read left to issue
    eng_rd.en = (state == dma_pkg::COPY);
    eng_rd.addr = rd_addr;
    eng_rd.data = '0;
    // First COPY cycle has nothing to write yet
    eng_wr.en = (state == dma_pkg::DRAIN) || ((state == dma_pkg::COPY) && wr_full);
    eng_wr.addr = wr_addr;
    // Fresh word from the array, or the held one after a stall
    eng_wr.data = rd_ret ? mem_rdata : hold_data;
  end

  assign done_en = (state == dma_pkg::FINISH);
  assign done_pos = eng_pos;

  ////////////////////
  // FSM
  ////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= dma_pkg::IDLE;
      eng_pos <= '0;
      rd_ret <= 1'b0;
      wr_full <= 1'b0;
    end else begin
      // Array output is ours next cycle only if the read went through
      rd_ret <= eng_rd.en && !eng_stall;
      case (state)
        dma_pkg::IDLE: begin
          if (found) begin
            eng_pos <= next_pos;
            state <= dma_pkg::LOAD;
          end
        end
        dma_pkg::LOAD: begin
          wr_full <= 1'b0;
          if (eng_req.size == '0) begin
            state <= dma_pkg::FINISH;
          end else begin
            state <= dma_pkg::COPY;
          end
        end
        dma_pkg::COPY: begin
          // Stalled cycle is repeated as is
          if (!eng_stall) begin
            wr_full <= 1'b1;
            if (rd_left == dma_pkg::xfer_size_t'(1)) begin
              state <= dma_pkg::DRAIN;
            end
          end
        end
        dma_pkg::DRAIN: begin
          if (!eng_stall) begin
            state <= dma_pkg::FINISH;
          end
        end
        dma_pkg::FINISH: begin
          state <= dma_pkg::IDLE;
        end
        default: begin
          state <= dma_pkg::IDLE;
        end
      endcase
    end
  end

  ////////////////////
  // Copy datapath
  ////////////////////

  always_ff @(posedge clk) begin
    if (rd_ret) begin
      hold_data <= mem_rdata;
    end
    if (state == dma_pkg::LOAD) begin
      rd_left <= eng_req.size;
      // Direction picks source and destination region
      if (eng_req.dir) begin
        rd_addr <= eng_req.raddr;
        wr_addr <= eng_req.laddr;
      end else begin
        rd_addr <= eng_req.laddr;
        wr_addr <= eng_req.raddr;
      end
    end else if (!eng_stall) begin
      if (eng_rd.en) begin
        rd_addr <= rd_addr + dma_pkg::mem_addr_t'(1);
        rd_left <= rd_left - dma_pkg::xfer_size_t'(1);
      end
      if (eng_wr.en) begin
        wr_addr <= wr_addr + dma_pkg::mem_addr_t'(1);
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+.
dma_pkg.sv
dma_reg_decode.sv
dma_request_table.sv
dma_transfer_engine.sv
dma_scratch_mem.sv
dma_top.sv
dma_props.sv
dma_tb.sv
